// File: design/fnd_pkg.sv
`default_nettype none

package fnd_pkg;

    ////////////////////////////////////////////////////////////////////
    // widths

    localparam int NUM_BUTTONS = 4;
    localparam int COUNT_W     = 16;
    localparam int DIGIT_W     = 4;   // one hex nibble
    localparam int NUM_DIGITS  = 4;
    localparam int SEG_W       = 8;   // a..g plus dp

    ////////////////////////////////////////////////////////////////////
    // button positions in the buttons vector

    localparam int BTN_UP    = 0;
    localparam int BTN_DOWN  = 1;
    localparam int BTN_LEFT  = 2;
    localparam int BTN_RIGHT = 3;

    ////////////////////////////////////////////////////////////////////
    // count word, seen whole or as display digits

    typedef union packed {
        logic [COUNT_W-1:0]                 word;
        logic [NUM_DIGITS-1:0][DIGIT_W-1:0] digit;  // digit[0] is bits 3:0
    } count_word_u;

    // bit 0 = segment a ... bit 6 = segment g, bit 7 = dp
    typedef logic [SEG_W-1:0] seg_pattern_t;

endpackage

`default_nettype wire

// File: design/btn_event_if.sv
`timescale 1ns/1ps
`default_nettype none

// one-cycle button events, no acknowledge
interface btn_event_if;

    logic up;
    logic down;
    logic left;
    logic right;

    modport producer (
        output up, down, left, right
    );

    modport consumer (
        input up, down, left, right
    );

endinterface

`default_nettype wire

// File: design/btn_debounce.sv
`timescale 1ns/1ps
`default_nettype none

module btn_debounce #(
    parameter int DEBOUNCE_DIV_BITS = 16
) (
    input  logic                             clk,
    input  logic                             reset_p,
    input  logic [fnd_pkg::NUM_BUTTONS-1:0] buttons,
    output logic [fnd_pkg::NUM_BUTTONS-1:0] debounced
);

    logic [DEBOUNCE_DIV_BITS-1:0] div_cnt;
    logic                         sample_tick;

    // free-running prescaler
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign sample_tick = (div_cnt == '1);  // one cycle per wrap

    // bounces shorter than one tick period never reach the register
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            debounced <= '0;
        end else if (sample_tick) begin
            debounced <= buttons;
        end
    end

endmodule

`default_nettype wire

// File: design/btn_edge_detector.sv
`timescale 1ns/1ps
`default_nettype none

module btn_edge_detector (
    input  logic                             clk,
    input  logic                             reset_p,
    input  logic [fnd_pkg::NUM_BUTTONS-1:0] debounced,
    btn_event_if.producer                    events
);

    logic [fnd_pkg::NUM_BUTTONS-1:0] cur_q;
    logic [fnd_pkg::NUM_BUTTONS-1:0] old_q;
    logic [fnd_pkg::NUM_BUTTONS-1:0] rise;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            cur_q <= '0;
            old_q <= '0;
        end else begin
            cur_q <= debounced;
            old_q <= cur_q;
        end
    end

    assign rise = cur_q & ~old_q;  // 0 -> 1 seen between the two stages

    // registered pulses, two cycles after debounced rises
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            events.up    <= 1'b0;
            events.down  <= 1'b0;
            events.left  <= 1'b0;
            events.right <= 1'b0;
        end else begin
            events.up    <= rise[fnd_pkg::BTN_UP];
            events.down  <= rise[fnd_pkg::BTN_DOWN];
            events.left  <= rise[fnd_pkg::BTN_LEFT];
            events.right <= rise[fnd_pkg::BTN_RIGHT];
        end
    end

endmodule

`default_nettype wire

// File: design/count_control.sv
`timescale 1ns/1ps
`default_nettype none

module count_control (
    input  logic                 clk,
    input  logic                 reset_p,
    btn_event_if.consumer        events,
    output fnd_pkg::count_word_u count
);

    localparam int W = fnd_pkg::COUNT_W;

    ////////////////////////////////////////////////////////////////////
    // one operation per cycle, up > down > left > right

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            count.word <= '0;
        end else begin
            if (events.up) begin
                count.word <= count.word + 1'b1;  // wraps FFFF -> 0
            end else if (events.down) begin
                count.word <= count.word - 1'b1;  // wraps 0 -> FFFF
            end else if (events.left) begin
                // msb comes around to bit 0
                count.word <= {count.word[W-2:0], count.word[W-1]};
            end else if (events.right) begin
                count.word <= {count.word[0], count.word[W-1:1]};
            end
            // lower-priority events in the same cycle are dropped
        end
    end

endmodule

`default_nettype wire

// File: design/fnd_scan.sv
`timescale 1ns/1ps
`default_nettype none

module fnd_scan #(
    parameter int SCAN_DIV_BITS = 16
) (
    input  logic                            clk,
    input  logic                            reset_p,
    output logic [fnd_pkg::NUM_DIGITS-1:0] com
);

    logic [SCAN_DIV_BITS-1:0] div_cnt;
    logic                     scan_tick;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign scan_tick = (div_cnt == '1);

    ////////////////////////////////////////////////////////////////////
    // active-low digit ring, low bit walks toward the msb

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            com <= 4'b1110;
        end else if (scan_tick) begin
            case (com)
                4'b1110: com <= 4'b1101;
                4'b1101: com <= 4'b1011;
                4'b1011: com <= 4'b0111;
                4'b0111: com <= 4'b1110;
                default: com <= 4'b1110;  // recover from a bad state
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/fnd_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module fnd_encoder (
    input  fnd_pkg::count_word_u            count,
    input  logic [fnd_pkg::NUM_DIGITS-1:0] com,
    output fnd_pkg::seg_pattern_t           seg_7
);

    logic [$clog2(fnd_pkg::NUM_DIGITS)-1:0] digit_sel;
    logic [fnd_pkg::DIGIT_W-1:0]            nibble;
    fnd_pkg::seg_pattern_t                  seg_on;  // active high, dp in bit 7

    // digit whose enable is low
    always_comb begin
        case (com)
            4'b1110: digit_sel = 2'd0;
            4'b1101: digit_sel = 2'd1;
            4'b1011: digit_sel = 2'd2;
            4'b0111: digit_sel = 2'd3;
            default: digit_sel = 2'd0;
        endcase
    end

    assign nibble = count.digit[digit_sel];

    ////////////////////////////////////////////////////////////////////
    // hex font, gfedcba

    always_comb begin
        case (nibble)
            4'h0: seg_on = 8'h3F;
            4'h1: seg_on = 8'h06;
            4'h2: seg_on = 8'h5B;
            4'h3: seg_on = 8'h4F;
            4'h4: seg_on = 8'h66;
            4'h5: seg_on = 8'h6D;
            4'h6: seg_on = 8'h7D;
            4'h7: seg_on = 8'h07;
            4'h8: seg_on = 8'h7F;
            4'h9: seg_on = 8'h6F;
            4'hA: seg_on = 8'h77;
            4'hB: seg_on = 8'h7C;  // lower case b
            4'hC: seg_on = 8'h39;
            4'hD: seg_on = 8'h5E;  // lower case d
            4'hE: seg_on = 8'h79;
            default: seg_on = 8'h71;  // F
        endcase
    end

    // common-anode panel, dp stays dark
    assign seg_7 = ~seg_on;

endmodule

`default_nettype wire

// File: design/fnd_counter_top.sv
`timescale 1ns/1ps
`default_nettype none

module fnd_counter_top #(
    parameter int DEBOUNCE_DIV_BITS = 16,
    parameter int SCAN_DIV_BITS     = 16
) (
    input  logic                             clk,
    input  logic                             reset_p,
    input  logic [fnd_pkg::NUM_BUTTONS-1:0] buttons,     // raw, active high
    output logic [fnd_pkg::COUNT_W-1:0]     count,
    output logic [fnd_pkg::SEG_W-1:0]       seg_7,       // active low
    output logic [fnd_pkg::NUM_DIGITS-1:0]  com          // active low
);

    logic [fnd_pkg::NUM_BUTTONS-1:0] debounced;
    fnd_pkg::count_word_u            count_w;

    btn_event_if btn_events ();

    ////////////////////////////////////////////////////////////////////
    // button path

    btn_debounce #(
        .DEBOUNCE_DIV_BITS (DEBOUNCE_DIV_BITS)
    ) u_debounce (
        .clk       (clk),
        .reset_p   (reset_p),
        .buttons   (buttons),
        .debounced (debounced)
    );

    btn_edge_detector u_edge (
        .clk       (clk),
        .reset_p   (reset_p),
        .debounced (debounced),
        .events    (btn_events.producer)
    );

    count_control u_count (
        .clk     (clk),
        .reset_p (reset_p),
        .events  (btn_events.consumer),
        .count   (count_w)
    );

    ////////////////////////////////////////////////////////////////////
    // display path

    fnd_scan #(
        .SCAN_DIV_BITS (SCAN_DIV_BITS)
    ) u_scan (
        .clk     (clk),
        .reset_p (reset_p),
        .com     (com)
    );

    fnd_encoder u_encoder (
        .count (count_w),
        .com   (com),
        .seg_7 (seg_7)
    );

    assign count = count_w.word;  // plain vector at the pins

endmodule

`default_nettype wire

// File: bench/fnd_counter_props.sv
`timescale 1ns/1ps
`default_nettype none

module fnd_counter_props (
    input logic                            clk,
    input logic                            reset_p,
    input logic [fnd_pkg::NUM_DIGITS-1:0] com,
    input logic [fnd_pkg::COUNT_W-1:0]    count,
    input logic                            ev_up,
    input logic                            ev_down,
    input logic                            ev_left,
    input logic                            ev_right
);

    logic [fnd_pkg::NUM_BUTTONS-1:0] ev;

    assign ev = {ev_right, ev_left, ev_down, ev_up};

    // one digit enabled at a time
    a_com_one_low: assert property (@(posedge clk) disable iff (reset_p)
        $onehot(~com))
        else $error("com does not hold exactly one low bit");

    // the count only moves right after an event
    a_count_after_event: assert property (@(posedge clk) disable iff (reset_p)
        (count != $past(count)) |-> $past(|ev))
        else $error("count changed without a preceding event pulse");

    // every event is a single-cycle pulse
    a_event_one_cycle: assert property (@(posedge clk) disable iff (reset_p)
        (ev & $past(ev)) == '0)
        else $error("an event pulse lasted more than one cycle");

endmodule

bind fnd_counter_top fnd_counter_props u_props (
    .clk      (clk),
    .reset_p  (reset_p),
    .com      (com),
    .count    (count),
    .ev_up    (btn_events.up),
    .ev_down  (btn_events.down),
    .ev_left  (btn_events.left),
    .ev_right (btn_events.right)
);

`default_nettype wire

// File: bench/tb_fnd_counter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fnd_counter;

    localparam int DEB_BITS     = 4;
    localparam int SCAN_BITS    = 3;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int PRESS_HALF   = 2**DEB_BITS + 8;      // hold time, same again released
    localparam int MAX_PRESSES  = 77;                   // upper bound over all tests
    localparam int SCAN_WINDOW  = 4 * 2**SCAN_BITS + 8;
    localparam int TEST_CYCLES  = MAX_PRESSES * 2 * PRESS_HALF + SCAN_WINDOW + RESET_CYCLES;

    logic                            clk;
    logic                            reset_p;
    logic [fnd_pkg::NUM_BUTTONS-1:0] buttons;
    logic [fnd_pkg::COUNT_W-1:0]     count;
    logic [fnd_pkg::SEG_W-1:0]       seg_7;
    logic [fnd_pkg::NUM_DIGITS-1:0]  com;

    logic [fnd_pkg::COUNT_W-1:0]    exp_q[$];    // expected count after each press
    logic [fnd_pkg::COUNT_W-1:0]    model_count;
    logic [fnd_pkg::NUM_DIGITS-1:0] seen_com;
    logic                           scan_watch;
    int rd_idx;
    int check_count;
    int cmp_errors;
    int stim_errors;
    int errors_at_start;
    int tests_run;
    int tests_failed;

    fnd_counter_top #(
        .DEBOUNCE_DIV_BITS (DEB_BITS),
        .SCAN_DIV_BITS     (SCAN_BITS)
    ) dut (
        .clk     (clk),
        .reset_p (reset_p),
        .buttons (buttons),
        .count   (count),
        .seg_7   (seg_7),
        .com     (com)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model

    // mask bits follow the button indices, only the top-priority one counts
    function automatic logic [fnd_pkg::COUNT_W-1:0] next_count(
        input logic [fnd_pkg::COUNT_W-1:0]     old,
        input logic [fnd_pkg::NUM_BUTTONS-1:0] mask
    );
        if (mask[fnd_pkg::BTN_UP]) begin
            return old + 16'd1;
        end else if (mask[fnd_pkg::BTN_DOWN]) begin
            return old - 16'd1;
        end else if (mask[fnd_pkg::BTN_LEFT]) begin
            return {old[14:0], old[15]};
        end else if (mask[fnd_pkg::BTN_RIGHT]) begin
            return {old[0], old[15:1]};
        end
        return old;
    endfunction

    // common-anode codes, dp dark
    function automatic logic [fnd_pkg::SEG_W-1:0] seg_font(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'hC0;
            4'h1: return 8'hF9;
            4'h2: return 8'hA4;
            4'h3: return 8'hB0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hF8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'hA: return 8'h88;
            4'hB: return 8'h83;
            4'hC: return 8'hC6;
            4'hD: return 8'hA1;
            4'hE: return 8'h86;
            default: return 8'h8E;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // comparison, sampled mid-cycle

    initial begin : compare_results
        int zeros;
        int sel;
        logic [fnd_pkg::SEG_W-1:0] exp_seg;
        logic was_watching;
        rd_idx       = 0;
        check_count  = 0;
        cmp_errors   = 0;
        seen_com     = '0;
        was_watching = 1'b0;
        forever begin
            @(negedge clk);
            if (scan_watch) begin
                if (!was_watching) begin
                    seen_com = '0;  // new scan window
                end
                zeros = 0;
                sel   = 0;
                for (int i = 0; i < fnd_pkg::NUM_DIGITS; i++) begin
                    if (!com[i]) begin
                        zeros++;
                        sel = i;
                    end
                end
                if (zeros != 1) begin
                    cmp_errors++;
                    $display("com %b does not enable exactly one digit", com);
                end else begin
                    seen_com[sel] = 1'b1;
                    exp_seg = seg_font(model_count[sel*4 +: 4]);
                    if (seg_7 !== exp_seg) begin
                        cmp_errors++;
                        $display("[ERROR] seg_7: com %h expected %h, got %h",
                                 com, exp_seg, seg_7);
                    end
                end
            end
            was_watching = scan_watch;
            while (rd_idx < exp_q.size()) begin
                check_count++;
                if (count !== exp_q[rd_idx]) begin
                    cmp_errors++;
                    $display("[ERROR] count: expected %h, got %h", exp_q[rd_idx], count);
                end
                rd_idx++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus

    task automatic press_buttons(input logic [fnd_pkg::NUM_BUTTONS-1:0] mask);
        buttons = mask;
        repeat (PRESS_HALF) @(negedge clk);
        buttons = '0;
        repeat (PRESS_HALF) @(negedge clk);
        model_count = next_count(model_count, mask);
        exp_q.push_back(model_count);
    endtask

    task automatic press_one(input int btn);
        press_buttons(4'b0001 << btn);
    endtask

    task automatic finish_test(input string name);
        int errs;
        while (rd_idx < exp_q.size()) @(negedge clk);  // let pending checks drain
        errs = cmp_errors + stim_errors - errors_at_start;
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errs);
        end
        errors_at_start = cmp_errors + stim_errors;
    endtask

    initial begin : run_tests
        int n;
        void'($urandom(32'h4ef9_2846));
        reset_p         = 1'b1;
        buttons         = '0;
        scan_watch      = 1'b0;
        model_count     = '0;
        stim_errors     = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_p = 1'b0;

        // 1: idle state right after reset
        if (com !== 4'b1110) begin
            stim_errors++;
            $display("[ERROR] com: expected %h, got %h", 4'b1110, com);
        end
        if (seg_7 !== seg_font(4'h0)) begin
            stim_errors++;
            $display("[ERROR] seg_7: expected %h, got %h", seg_font(4'h0), seg_7);
        end
        exp_q.push_back(model_count);
        finish_test("reset state");

        // 2: wraparound, then random runs of up and down
        press_one(fnd_pkg::BTN_DOWN);
        press_one(fnd_pkg::BTN_UP);
        for (int r = 0; r < 3; r++) begin
            n = $urandom_range(3, 1);
            repeat (n) press_one(fnd_pkg::BTN_UP);
            n = $urandom_range(3, 1);
            repeat (n) press_one(fnd_pkg::BTN_DOWN);
        end
        finish_test("up and down");

        // 3: one bit walked around both ends, starting from zero
        while (model_count != '0) begin
            if (model_count[fnd_pkg::COUNT_W-1]) begin
                press_one(fnd_pkg::BTN_UP);
            end else begin
                press_one(fnd_pkg::BTN_DOWN);
            end
        end
        press_one(fnd_pkg::BTN_UP);      // bit 0 set
        press_one(fnd_pkg::BTN_RIGHT);   // bit 0 to bit 15
        press_one(fnd_pkg::BTN_LEFT);    // bit 15 to bit 0
        press_one(fnd_pkg::BTN_RIGHT);
        press_one(fnd_pkg::BTN_RIGHT);
        press_one(fnd_pkg::BTN_LEFT);
        finish_test("rotations");

        // 4: simultaneous presses, mask is {right, left, down, up}
        press_buttons(4'b1111);
        press_buttons(4'b1110);
        press_buttons(4'b1100);
        press_buttons(4'b0011);
        press_buttons(4'b1010);
        finish_test("priority");

        // 5: random single presses
        for (int p = 0; p < 40; p++) begin
            press_one($urandom_range(3, 0));
        end
        finish_test("random presses");

        // 6: full display scan with the count held
        scan_watch = 1'b1;
        repeat (SCAN_WINDOW) @(negedge clk);
        scan_watch = 1'b0;
        if (seen_com !== 4'b1111) begin
            stim_errors++;
            $display("not every digit enable appeared during the scan, seen %b", seen_com);
        end
        finish_test("display scan");

        $display("summary: %0d tests, %0d failed, %0d count checks, %0d errors",
                 tests_run, tests_failed, check_count, cmp_errors + stim_errors);
        if (cmp_errors + stim_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", 2 * TEST_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
design/fnd_pkg.sv
design/btn_event_if.sv
design/btn_debounce.sv
design/btn_edge_detector.sv
design/count_control.sv
design/fnd_scan.sv
design/fnd_encoder.sv
design/fnd_counter_top.sv
bench/fnd_counter_props.sv
bench/tb_fnd_counter.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_fnd_counter -Mdir obj_dir -f flist.f \
    || { echo "build failed"; exit 1; }

./obj_dir/Vtb_fnd_counter | tee /dev/stderr | grep -x "Everything OK" > /dev/null \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }
